// File: hdl/ioMapPkg.sv
// I/O map of the peripheral block. Offsets are byte offsets within the I/O area
// and every register is one 32-bit word. Vectors are word-aligned handler addresses.
package ioMapPkg;

	typedef logic [31:0] busData_t;		// Bus data word
	typedef logic [7:0]  busAddr_t;		// Byte offset in I/O area
	typedef logic [29:0] vector_t;		// Handler address [31:2]
	typedef logic [3:0]  irqEnable_t;	// One enable per source
	typedef logic [1:0]  vecSel_t;		// Vector table index

	//////////////////////////////////////////////////
	// Register offsets
	localparam busAddr_t uartDataOff   = 8'h00;	// RX byte on read, TX on write
	localparam busAddr_t uartFlagsOff  = 8'h04;
	localparam busAddr_t pwmDutyOff    = 8'h20;	// Write only
	localparam busAddr_t timerOff      = 8'h60;
	localparam busAddr_t irqEnableOff  = 8'hE0;
	localparam busAddr_t irqVectorBase = 8'hF0;	// Three words

	// Enable register bits
	localparam int irqRxBit    = 0;
	localparam int irqTxBit    = 1;
	localparam int irqPwmBit   = 2;
	localparam int irqCtrlCBit = 3;

	// Vector table slots
	localparam vecSel_t vecCtrlC = 2'd0;
	localparam vecSel_t vecUart  = 2'd1;
	localparam vecSel_t vecPwm   = 2'd2;

	// Flags word bits
	localparam int flagRxValid   = 0;
	localparam int flagTxReady   = 1;
	localparam int flagFrameErr  = 2;
	localparam int flagRxOverrun = 3;
	localparam int flagCtrlC     = 4;
	localparam int flagPwm       = 5;

endpackage

// File: hdl/periphPkg.sv
// Serial frame and PWM constants. The UART is 8N1 only.
// The divider default suits the target clock and is overridden per instance.
package periphPkg;

	//////////////////////////////////////////////////
	// UART
	typedef logic [7:0] uartByte_t;		// One data byte

	localparam int defaultDivider = 208;	// Clocks per bit

	localparam uartByte_t ctrlCCode = 8'h03;	// ETX from the terminal

	// Receiver sequence
	typedef enum logic {
		rxIdle,		// Waiting for a start bit
		rxShift		// Data bits, then stop bit
	} rxState_t;

	//////////////////////////////////////////////////
	// PWM
	typedef logic [7:0] pwmCount_t;

	// Terminal count
	// 181 clocks per period
	localparam pwmCount_t pwmTop = 8'd180;

endpackage

// File: hdl/ioBus.sv
// Decoded strobes from the register block to the peripherals.
// All strobes are single-cycle and qualified by the bus write or read.
interface ioBus;
	import ioMapPkg::*;

	logic     uartTx;	// Load TX byte, start frame
	logic     uartRd;	// RX byte read, clear flags
	logic     pwmWr;	// New duty into holding reg
	busData_t wdata;	// Bus write data

	// Register block drives everything
	modport regs (
		output uartTx, uartRd, pwmWr, wdata
	);

	modport uart (
		input uartTx, uartRd, wdata
	);

	modport pwm (
		input pwmWr, wdata
	);

endinterface

// File: hdl/uartCore.sv
// 8N1 UART with a fixed divider. A TX write while busy restarts the frame.
// rxd is resynchronized here. The divider must be 4 or more.
module uartCore #(
	parameter int divider = periphPkg::defaultDivider	// Clocks per bit
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rxd,
	ioBus.uart                   bus,
	output periphPkg::uartByte_t rxByte,
	output logic                 rxValid,
	output logic                 rxOverrun,
	output logic                 frameErr,
	output logic                 txReady,
	output logic                 txd
);
	import periphPkg::*;

	localparam int divBits = $clog2(divider);

	//////////////////////////////////////////////////
	// Transmitter
	uartByte_t          txByte;
	logic [divBits-1:0] txDiv;		// Bit time
	logic [8:0]         txSh;		// Data plus start bit
	logic [3:0]         txBits;		// Bits left, 0 is idle
	logic               txTick;

	assign txByte = bus.wdata[7:0];
	assign txTick = (txDiv == divBits'(divider - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txDiv  <= '0;
			txSh   <= '1;		// Line idles high
			txBits <= '0;
		end else if (bus.uartTx) begin
			txDiv  <= '0;
			txSh   <= {txByte, 1'b0};	// Start bit out first
			txBits <= 4'd10;		// Start, 8 data, stop
		end else begin
			txDiv <= txTick ? '0 : txDiv + 1'b1;
			if (txTick) begin
				txSh <= {1'b1, txSh[8:1]};	// Ones fill in as stop bit
				if (txBits != 4'd0)
					txBits <= txBits - 1'b1;
			end
		end
	end

	assign txd     = txSh[0];
	assign txReady = (txBits == 4'd0);

	//////////////////////////////////////////////////
	// Receiver
	logic [1:0]         rxSync;		// Two-flop synchronizer
	logic               rxBit;
	logic [divBits-1:0] rxDiv;
	logic               rxSample;	// Middle of bit
	rxState_t           rxState;
	uartByte_t          rxSh;
	logic [3:0]         rxCnt;		// Samples taken in frame
	logic               rxDone;
	logic               rxStop;		// Stop bit of last byte
	logic [1:0]         rxFlags;	// {overrun, valid}

	assign rxBit = rxSync[1];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxSync <= 2'b11;
			rxDiv  <= '0;
		end else begin
			rxSync <= {rxSync[0], rxd};
			// Realign on every line edge
			if ((rxSync[1] ^ rxSync[0]) || (rxDiv == divBits'(divider - 1)))
				rxDiv <= '0;
			else
				rxDiv <= rxDiv + 1'b1;
		end
	end

	assign rxSample = (rxDiv == divBits'(divider / 2 - 1));
	assign rxDone   = (rxState == rxShift) && rxSample && (rxCnt == 4'd8);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxState <= rxIdle;
			rxCnt   <= '0;
		end else begin
			case (rxState)
				rxIdle: if (rxSample && !rxBit) begin	// Low at mid start bit
					rxState <= rxShift;
					rxCnt   <= '0;
				end
				rxShift: if (rxSample) begin
					rxCnt <= rxCnt + 1'b1;
					if (rxCnt == 4'd8)
						rxState <= rxIdle;	// Stop bit taken
				end
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk) begin
		if (rxState == rxShift && rxSample && rxCnt != 4'd8)
			rxSh <= {rxBit, rxSh[7:1]};
		if (rxDone)
			rxByte <= rxSh;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxStop  <= 1'b1;
			rxFlags <= '0;
		end else if (rxDone) begin
			rxStop  <= rxBit;
			rxFlags <= {rxFlags[0], 1'b1};	// Old valid becomes overrun
		end else if (bus.uartRd) begin
			rxFlags <= '0;
		end
	end

	assign rxValid   = rxFlags[0];
	assign rxOverrun = rxFlags[1];
	assign frameErr  = ~rxStop;

endmodule

// File: hdl/pwmGen.sv
// PWM with a fixed 181-clock period. A new duty takes effect at the next
// terminal count. Duties above the period keep the output high.
module pwmGen (
	input  logic clk,
	input  logic reset,
	ioBus.pwm    bus,
	output logic pwmOut,
	output logic pwmFlag
);
	import periphPkg::*;

	pwmCount_t pwmCnt;		// Period counter
	pwmCount_t pwmDuty;		// Holding reg, bus side
	pwmCount_t pwmCmp;		// Compare value in use
	logic      pwmTc;
	logic      pwmZc;

	assign pwmTc = (pwmCnt == pwmTop);
	assign pwmZc = (pwmCnt == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwmCnt  <= '0;
			pwmDuty <= '0;
			pwmCmp  <= '0;
		end else begin
			pwmCnt <= pwmTc ? '0 : pwmCnt + 1'b1;
			if (bus.pwmWr)
				pwmDuty <= bus.wdata[7:0];
			if (pwmTc)
				pwmCmp <= pwmDuty;	// Swap only between periods
		end
	end

	// High over counts 1..duty, compare wins so duty 0 stays low
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwmOut  <= 1'b0;
			pwmFlag <= 1'b0;
		end else begin
			pwmOut  <= (pwmCnt == pwmCmp) ? 1'b0 : (pwmZc ? 1'b1 : pwmOut);
			pwmFlag <= pwmZc ? 1'b1 : (bus.pwmWr ? 1'b0 : pwmFlag);	// Period start
		end
	end

endmodule

// File: hdl/ioRegs.sv
// Register block of the I/O area: decode, read mux, timer and interrupts.
// Reads are combinational from busAddr. Unmapped and write-only offsets read 0.
// The vector table has no reset and must be written before irq is enabled.
module ioRegs (
	input  logic                 clk,
	input  logic                 reset,
	input  ioMapPkg::busAddr_t   busAddr,
	input  ioMapPkg::busData_t   busWdata,
	input  logic                 busWr,
	input  logic                 busRd,
	output ioMapPkg::busData_t   busRdata,
	ioBus.regs                   bus,
	input  periphPkg::uartByte_t rxByte,
	input  logic                 rxValid,
	input  logic                 rxOverrun,
	input  logic                 frameErr,
	input  logic                 txReady,
	input  logic                 pwmFlag,
	output logic                 irq,
	output ioMapPkg::vector_t    ivector
);
	import ioMapPkg::*;
	import periphPkg::*;

	busData_t   timer;			// Free-running cycle count
	irqEnable_t irqEn;
	vector_t    vecTable [3];
	busAddr_t   vecOff;			// Offset into vector table
	logic       vecHit;
	vecSel_t    vecIdx;
	busData_t   flagsWord;
	logic       ctrlC;
	logic       ctrlCPend, uartPend, pwmPend;
	vecSel_t    vecSel;

	//////////////////////////////////////////////////
	// Decode
	assign bus.uartTx = busWr && (busAddr == uartDataOff);
	assign bus.uartRd = busRd && (busAddr == uartDataOff);
	assign bus.pwmWr  = busWr && (busAddr == pwmDutyOff);
	assign bus.wdata  = busWdata;

	// Offsets below the table wrap to large values
	assign vecOff = busAddr - irqVectorBase;
	assign vecHit = (vecOff < 8'd12) && (vecOff[1:0] == 2'b00);
	assign vecIdx = vecOff[3:2];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			timer <= '0;
			irqEn <= '0;
		end else begin
			timer <= timer + 1'b1;
			if (busWr && busAddr == irqEnableOff)
				irqEn <= busWdata[3:0];
		end
	end

	always_ff @(posedge clk) begin
		if (busWr && vecHit)
			vecTable[vecIdx] <= busWdata[31:2];	// Word aligned
	end

	//////////////////////////////////////////////////
	// Read mux
	assign ctrlC = rxValid && (rxByte == ctrlCCode);	// Unread ctrl-C

	always_comb begin
		flagsWord                = '0;
		flagsWord[flagRxValid]   = rxValid;
		flagsWord[flagTxReady]   = txReady;
		flagsWord[flagFrameErr]  = frameErr;
		flagsWord[flagRxOverrun] = rxOverrun;
		flagsWord[flagCtrlC]     = ctrlC;
		flagsWord[flagPwm]       = pwmFlag;
	end

	always_comb begin
		busRdata = '0;
		case (busAddr)
			uartDataOff:  busRdata = busData_t'(rxByte);
			uartFlagsOff: busRdata = flagsWord;
			timerOff:     busRdata = timer;
			irqEnableOff: busRdata = busData_t'(irqEn);
			default: if (vecHit) busRdata = {vecTable[vecIdx], 2'b00};
		endcase
	end

	//////////////////////////////////////////////////
	// Interrupts
	assign ctrlCPend = irqEn[irqCtrlCBit] && ctrlC;
	assign uartPend  = (irqEn[irqRxBit] && rxValid) || (irqEn[irqTxBit] && txReady);
	assign pwmPend   = irqEn[irqPwmBit] && pwmFlag;

	assign irq = ctrlCPend || uartPend || pwmPend;

	// Ctrl-C first, then UART, then PWM
	assign vecSel  = ctrlCPend ? vecCtrlC : (uartPend ? vecUart : vecPwm);
	assign ivector = vecTable[vecSel];

endmodule

// File: hdl/ioSubsystem.sv
// Peripheral block top. One clock domain, single-cycle bus strobes
// and no wait states. busRdata is valid in the cycle of the read.
module ioSubsystem #(
	parameter int divider = periphPkg::defaultDivider	// UART clocks per bit
) (
	input  logic               clk,
	input  logic               reset,
	input  ioMapPkg::busAddr_t busAddr,
	input  ioMapPkg::busData_t busWdata,
	input  logic               busWr,
	input  logic               busRd,
	input  logic               rxd,
	output ioMapPkg::busData_t busRdata,
	output logic               txd,
	output logic               pwmOut,
	output logic               irq,
	output ioMapPkg::vector_t  ivector
);
	import periphPkg::*;

	ioBus bus ();

	// Status back to the register block
	uartByte_t rxByte;
	logic      rxValid, rxOverrun, frameErr, txReady;
	logic      pwmFlag;

	ioRegs ioRegs_i (
		.clk(clk), .reset(reset),
		.busAddr(busAddr), .busWdata(busWdata), .busWr(busWr), .busRd(busRd),
		.busRdata(busRdata), .bus(bus.regs),
		.rxByte(rxByte), .rxValid(rxValid), .rxOverrun(rxOverrun),
		.frameErr(frameErr), .txReady(txReady), .pwmFlag(pwmFlag),
		.irq(irq), .ivector(ivector)
	);

	uartCore #(.divider(divider)) uartCore_i (
		.clk(clk), .reset(reset), .rxd(rxd), .bus(bus.uart),
		.rxByte(rxByte), .rxValid(rxValid), .rxOverrun(rxOverrun),
		.frameErr(frameErr), .txReady(txReady), .txd(txd)
	);

	pwmGen pwmGen_i (
		.clk(clk), .reset(reset), .bus(bus.pwm),
		.pwmOut(pwmOut), .pwmFlag(pwmFlag)
	);

endmodule

// File: testbench/ioSubsystem_sva.sv
// Assertions on UART idle and interrupt gating, bound into the top level.
// All checks are off while reset is high.
module ioSubsystem_sva (
	input logic                 clk,
	input logic                 reset,
	input logic                 txd,
	input logic                 txReady,
	input logic                 rxValid,
	input logic                 rxOverrun,
	input logic                 irq,
	input ioMapPkg::irqEnable_t irqEn
);
	txIdleHigh: assert property (@(posedge clk) disable iff (reset) txReady |-> txd)
		else $error("txd low while the transmitter is idle");

	// No source enabled, no request
	irqGated: assert property (@(posedge clk) disable iff (reset) (irqEn == '0) |-> !irq)
		else $error("irq high with all enables clear");

	overrunValid: assert property (@(posedge clk) disable iff (reset) rxOverrun |-> rxValid)
		else $error("rxOverrun set without rxValid");

endmodule

bind ioSubsystem ioSubsystem_sva ioSubsystem_sva_i (
	.clk(clk), .reset(reset), .txd(txd), .txReady(txReady),
	.rxValid(rxValid), .rxOverrun(rxOverrun), .irq(irq), .irqEn(ioRegs_i.irqEn)
);

// File: testbench/ioSubsystem_tb.sv
// Directed testbench for the peripheral block, UART divider 16.
// Inputs change on the falling edge and outputs are sampled in the low phase.
// Stops at the first mismatch or timeout.
module ioSubsystem_tb;
	import ioMapPkg::*;
	import periphPkg::*;

	localparam int divider   = 16;
	localparam int pollLimit = 200;		// Flag polls, two clocks each
	localparam int pwmPeriod = int'(pwmTop) + 1;

	logic        clk, reset, busWr, busRd, rxd, txd, pwmOut, irq;
	busAddr_t    busAddr;
	busData_t    busWdata, busRdata;
	vector_t     ivector;
	logic [31:0] seed;
	vector_t     vecs [3];		// Programmed handler addresses

	ioSubsystem #(.divider(divider)) ioSubsystem_i (
		.clk(clk), .reset(reset), .busAddr(busAddr), .busWdata(busWdata),
		.busWr(busWr), .busRd(busRd), .rxd(rxd), .busRdata(busRdata),
		.txd(txd), .pwmOut(pwmOut), .irq(irq), .ivector(ivector)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual, expected);
		if (actual !== expected)
			failRun($sformatf("error: %s is 0x%h, expected 0x%h", name, actual, expected));
	endtask

	//////////////////////////////////////////////////
	// Bus and serial line
	task automatic busWrite(input busAddr_t addr, input busData_t data);
		@(negedge clk);
		busAddr  = addr;
		busWdata = data;
		busWr    = 1'b1;
		@(negedge clk);
		busWr = 1'b0;		// One rising edge with the strobe
	endtask

	task automatic busRead(input busAddr_t addr, output busData_t data);
		@(negedge clk);
		busAddr = addr;
		busRd   = 1'b1;
		#2 data = busRdata;	// Combinational read data
		@(negedge clk);
		busRd = 1'b0;
	endtask

	task automatic checkFlag(input int pos, input string name, input logic expected);
		busData_t flags;
		busRead(uartFlagsOff, flags);
		checkValue(name, 32'(flags[pos]), 32'(expected));
	endtask

	task automatic waitFlag(input int pos, input logic value, input string what);
		busData_t flags;
		int       polls;
		polls = 0;
		busRead(uartFlagsOff, flags);
		while (flags[pos] !== value) begin
			if (polls == pollLimit)
				failRun({"timeout waiting for ", what});
			polls++;
			busRead(uartFlagsOff, flags);
		end
	endtask

	task automatic serialSend(input uartByte_t data, input logic stopBit);
		logic [9:0] frame;
		frame = {stopBit, data, 1'b0};
		@(negedge clk);
		for (int i = 0; i < 10; i++) begin
			rxd = frame[i];			// LSB first after start
			repeat (divider) @(negedge clk);
		end
		rxd = 1'b1;				// One bit of idle line
		repeat (divider) @(negedge clk);
	endtask

	task automatic serialReceive(output uartByte_t data, output logic stopBit);
		logic [9:0] frame;
		int         waitCnt;
		waitCnt = 0;
		while (txd !== 1'b0) begin
			if (waitCnt == 4 * divider)
				failRun("timeout waiting for the TX start bit");
			waitCnt++;
			@(negedge clk);
		end
		repeat (divider / 2) @(negedge clk);	// Middle of start bit
		for (int i = 0; i < 10; i++) begin
			frame[i] = txd;
			if (i < 9)
				repeat (divider) @(negedge clk);
		end
		checkValue("txd start bit", 32'(frame[0]), 32'h0);
		data    = frame[8:1];
		stopBit = frame[9];
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	task automatic testReset;
		busData_t flags, t0, t1;
		reset = 1'b1;
		repeat (14) @(negedge clk);
		busRead(uartFlagsOff, flags);		// Still in reset
		checkValue("flags", flags, 32'h1 << flagTxReady);
		checkValue("txd", 32'(txd), 32'h1);
		checkValue("pwmOut", 32'(pwmOut), 32'h0);
		checkValue("irq", 32'(irq), 32'h0);
		reset = 1'b0;				// After 16 cycles
		busRead(timerOff, t0);
		repeat (10) @(negedge clk);
		busRead(timerOff, t1);			// 12 edges after the first read
		checkValue("timer delta", t1 - t0, 32'd12);
	endtask

	task automatic testTransmit;
		uartByte_t b, got;
		logic      stopBit;
		for (int n = 0; n < 4; n++) begin
			seed = lcgStep(seed);
			b    = seed[23:16];
			busWrite(uartDataOff, busData_t'(b));
			checkFlag(flagTxReady, "flags.txReady", 1'b0);
			serialReceive(got, stopBit);
			checkValue("txd data", 32'(got), 32'(b));
			checkValue("txd stop bit", 32'(stopBit), 32'h1);
			waitFlag(flagTxReady, 1'b1, "txReady");
		end
	endtask

	task automatic testReceive;
		uartByte_t a, b;
		busData_t  data;
		for (int n = 0; n < 3; n++) begin
			seed = lcgStep(seed);
			b    = seed[15:8];
			serialSend(b, 1'b1);
			waitFlag(flagRxValid, 1'b1, "rxValid");
			busRead(uartDataOff, data);
			checkValue("rxByte", data, busData_t'(b));
			checkFlag(flagRxValid, "flags.rxValid", 1'b0);
		end
		seed = lcgStep(seed);
		a    = seed[31:24];
		b    = seed[7:0];
		serialSend(a, 1'b1);			// Two bytes, no read between
		serialSend(b, 1'b1);
		waitFlag(flagRxValid, 1'b1, "rxValid");
		checkFlag(flagRxOverrun, "flags.rxOverrun", 1'b1);
		busRead(uartDataOff, data);
		checkValue("rxByte", data, busData_t'(b));	// Newest byte kept
		checkFlag(flagRxOverrun, "flags.rxOverrun", 1'b0);
		serialSend(a, 1'b0);			// Low stop bit
		waitFlag(flagRxValid, 1'b1, "rxValid");
		checkFlag(flagFrameErr, "flags.frameErr", 1'b1);
		busRead(uartDataOff, data);
		serialSend(b, 1'b1);
		waitFlag(flagRxValid, 1'b1, "rxValid");
		checkFlag(flagFrameErr, "flags.frameErr", 1'b0);
		busRead(uartDataOff, data);
	endtask

	task automatic checkPwmDuty(input pwmCount_t duty);
		int highs;
		busWrite(pwmDutyOff, busData_t'(duty));
		waitFlag(flagPwm, 1'b1, "pwmFlag");
		busWrite(pwmDutyOff, busData_t'(duty));	// Same duty, clears flag
		checkFlag(flagPwm, "flags.pwmFlag", 1'b0);
		repeat (pwmPeriod) @(negedge clk);		// Past the switch-over
		highs = 0;
		repeat (pwmPeriod) begin		// Any full-period window
			@(negedge clk);
			if (pwmOut)
				highs++;
		end
		checkValue("pwmOut high clocks", 32'(highs), 32'(duty));
	endtask

	task automatic testInterrupts;
		busData_t data;
		for (int i = 0; i < 3; i++) begin
			seed    = lcgStep(seed);
			vecs[i] = seed[31:2];
			busWrite(irqVectorBase + busAddr_t'(4 * i), {vecs[i], 2'b00});
			busRead(irqVectorBase + busAddr_t'(4 * i), data);
			checkValue("vector readback", data, {vecs[i], 2'b00});
		end
		busWrite(irqEnableOff, 32'hF);
		waitFlag(flagPwm, 1'b1, "pwmFlag");	// All three sources pending
		serialSend(ctrlCCode, 1'b1);
		waitFlag(flagRxValid, 1'b1, "rxValid");
		checkFlag(flagCtrlC, "flags.ctrlC", 1'b1);
		checkValue("irq", 32'(irq), 32'h1);
		checkValue("ivector", 32'(ivector), 32'(vecs[vecCtrlC]));
		busRead(uartDataOff, data);		// Drops ctrl-C
		checkValue("ivector", 32'(ivector), 32'(vecs[vecUart]));	// UART over PWM
		busWrite(irqEnableOff, 32'h1 << irqTxBit);
		checkValue("irq", 32'(irq), 32'h1);
		checkValue("ivector", 32'(ivector), 32'(vecs[vecUart]));
		busWrite(irqEnableOff, 32'h1 << irqPwmBit);
		busWrite(pwmDutyOff, 32'd90);
		waitFlag(flagPwm, 1'b1, "pwmFlag");	// Fresh period start
		busWrite(pwmDutyOff, 32'd90);		// Early in the period, clears flag
		checkValue("irq", 32'(irq), 32'h0);
		waitFlag(flagPwm, 1'b1, "pwmFlag");
		checkValue("irq", 32'(irq), 32'h1);
		checkValue("ivector", 32'(ivector), 32'(vecs[vecPwm]));
	endtask

	initial begin
		clk      = 1'b0;
		reset    = 1'b1;
		busAddr  = '0;
		busWdata = '0;
		busWr    = 1'b0;
		busRd    = 1'b0;
		rxd      = 1'b1;		// Idle line
		seed     = 32'h26d7_3e6d;
		testReset();
		testTransmit();
		testReceive();
		seed = lcgStep(seed);
		checkPwmDuty(pwmCount_t'(seed[31:24] % 8'd180) + 8'd1);
		checkPwmDuty(8'd0);
		checkPwmDuty(pwmTop);
		testInterrupts();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: build.f
hdl/ioMapPkg.sv
hdl/periphPkg.sv
hdl/ioBus.sv
hdl/uartCore.sv
hdl/pwmGen.sv
hdl/ioRegs.sv
hdl/ioSubsystem.sv
testbench/ioSubsystem_sva.sv
testbench/ioSubsystem_tb.sv

// File: Makefile
TOP := ioSubsystem_tb

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
